// ==== run.sh ====
#!/bin/sh
# Builds and runs the testbench with Verilator, then judges the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tbMmioClient -f tb.f -o simMmioClient

# The run may stop early, the log decides the result
./obj_dir/simMmioClient > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log || ! grep -q "All checks passed" sim.log; then
  echo "RESULT: FAIL"
  exit 1
fi
echo "RESULT: PASS"

// ==== tb.f ====
+incdir+verilog
verilog/mmioPkg.sv
verilog/mmioAccessIf.sv
verilog/mmioBusDecode.sv
verilog/emifRegFile.sv
verilog/xmemDualPortRam.sv
verilog/mmioClient.sv
tb/mmioClient_checker.sv
tb/tbMmioClient.sv

// ==== tb/mmioClient_checker.sv ====
// Bound into the bus decoder and watches read-valid timing only, never the data
`timescale 1ns/1ps
`default_nettype none

module mmioClient_checker (
  input logic shlClk,
  input logic reset,
  input logic busCs,
  input logic busWe,
  input logic busRdValid
);

  logic busRead;   // Read strobe seen by the decoder

  assign busRead = busCs & ~busWe;

  // ---------------------------------------------------------------------------
  // Read-valid timing
  // ---------------------------------------------------------------------------
  validAfterRead: assert property (@(posedge shlClk) disable iff (reset)
                                   busRead |=> busRdValid)
    else $error("busRdValid missing one cycle after a read strobe");

  // No valid without a strobe the cycle before
  validNeedsRead: assert property (@(posedge shlClk) disable iff (reset)
                                   busRdValid |-> $past(busRead))
    else $error("busRdValid high with no read strobe the cycle before");

  validLowInReset: assert property (@(posedge shlClk)
                                    reset |=> !busRdValid)   // Registered clear
    else $error("busRdValid high during reset");

endmodule

bind mmioBusDecode mmioClient_checker busChecks (
  .shlClk     (shlClk),
  .reset      (reset),
  .busCs      (busCs),
  .busWe      (busWe),
  .busRdValid (busRdValid)
);

`default_nettype wire

// ==== tb/tbMmioClient.sv ====
// RAM has no reset contents so the fabric port fills every word before any window read
`timescale 1ns/1ps
`default_nettype none

`include "mmioClient_cfg.svh"

module tbMmioClient
  import mmioPkg::*;
();

  localparam int clkPeriod   = 100;
  localparam int driveDelay  = 5;     // After the rising edge
  localparam int statusReads = 32;
  localparam int memRounds   = 8;
  localparam int burstLen    = 8;     // Window bytes per round
  localparam int ctrlBits    = 170;   // All control outputs side by side
  localparam int testCycles  = 5 + 4*`REG_FILE_BYTES + 2*statusReads
                               + `XMEM_BYTES/`XMEM_LANES + memRounds*(7*burstLen);
  localparam int watchdogCycles = testCycles + testCycles/2;  // Half again as margin

  logic        shlClk;
  logic        reset;
  logic        busCs;
  logic        busWe;
  mmioAddrT    busAddr;
  mmioByteT    busWrData;
  mmioByteT    busRdData;
  logic        busRdValid;
  logic        mc0InitCalComplete, mc1InitCalComplete;
  logic        eth0CoreReady, eth0QpllLock;
  logic        eth0RxEqualizerMode;
  logic [3:0]  eth0TxDriverSwing;
  logic [4:0]  eth0TxPreCursor;
  logic [4:0]  eth0TxPostCursor;
  logic        eth0PcsLoopbackEn, eth0MacLoopbackEn, eth0MacAddrSwapEn;
  logic [47:0] nts0MacAddress;
  logic [31:0] nts0IpAddress, nts0SubNetMask, nts0GatewayAddr;
  logic [1:0]  roleUdpEchoCtrl, roleTcpEchoCtrl;
  logic        roleUdpPostPktEn, roleUdpCaptPktEn;
  logic        roleTcpPostPktEn, roleTcpCaptPktEn;
  logic        xmemEn;
  logic        xmemWren;
  xmemAddrT    xmemAddr;
  xmemWordT    xmemWrData;
  xmemWordT    xmemRdData;

  logic [ctrlBits-1:0] ctrlActual;
  logic [31:0]         lcgState;
  mmioByteT            shadowRegs [0:`REG_FILE_BYTES-1];
  mmioByteT            shadowMem  [0:`XMEM_BYTES-1];
  mmioByteT            expQ [$];   // Expected bytes of reads in flight
  mmioAddrT            addrQ [$];
  int                  failCount;

  mmioClient uut (.*);

  assign ctrlActual = {eth0RxEqualizerMode, eth0TxDriverSwing, eth0TxPreCursor,
                       eth0TxPostCursor, eth0PcsLoopbackEn, eth0MacLoopbackEn,
                       eth0MacAddrSwapEn, nts0MacAddress, nts0IpAddress, nts0SubNetMask,
                       nts0GatewayAddr, roleUdpEchoCtrl, roleUdpPostPktEn, roleUdpCaptPktEn,
                       roleTcpEchoCtrl, roleTcpPostPktEn, roleTcpCaptPktEn};

  initial
  begin
    shlClk = 1'b0;
    forever #(clkPeriod/2) shlClk = ~shlClk;
  end

  // ---------------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------------
  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;   // Callers take the upper bits
  endfunction

  function automatic logic isWritableRef(regAddrT a);
    return a inside {[7'h11:7'h13], 7'h20, [7'h22:7'h27], 7'h30, 7'h31,
                     [7'h34:7'h3F], [7'h70:7'h74], 7'h76, 7'h7F};
  endfunction

  function automatic mmioByteT defaultByte(regAddrT a);
    case (a)
      7'h00:                      return 8'h3D;
      7'h01, 7'h04:               return 8'h01;
      7'h03:                      return 8'h33;
      7'h05:                      return `TOP_DATE_YEAR;
      7'h06:                      return `TOP_DATE_MONTH;
      7'h07:                      return `TOP_DATE_DAY;
      7'h11:                      return 8'h41;   // PHY tuning
      7'h12, 7'h13:               return 8'h05;
      7'h38, 7'h39:               return 8'hFF;   // Subnet mask
      7'h3C:                      return 8'h0A;   // Gateway
      7'h3D:                      return 8'h02;
      7'h3F:                      return 8'h01;
      7'h70:                      return 8'hDE;   // Scratch
      7'h71:                      return 8'hAD;
      7'h72:                      return 8'hBE;
      7'h73:                      return 8'hEF;
      default:                    return 8'h00;
    endcase
  endfunction

  function automatic pageSelT pageNow();
    return shadowRegs[`REG_PAGE_SEL][`PAGE_BITS-1:0];
  endfunction

  // Value the bus must return for a read strobe issued now
  function automatic mmioByteT expectedRead(mmioAddrT a);
    regAddrT off;
    off = a[`REG_ADDR_WIDTH-1:0];
    if (a[`MMIO_ADDR_WIDTH-1])
      return shadowMem[{pageNow(), off}];
    if (off == `REG_PHY_STAT)
      return {4'b0000, eth0QpllLock, eth0CoreReady, mc1InitCalComplete, mc0InitCalComplete};
    if (isWritableRef(off))
      return shadowRegs[off];
    return defaultByte(off);   // Identity bytes, zero elsewhere
  endfunction

  function automatic xmemWordT expectedWord(xmemAddrT w);
    return {shadowMem[{w, 2'd3}], shadowMem[{w, 2'd2}],
            shadowMem[{w, 2'd1}], shadowMem[{w, 2'd0}]};   // Lane k is byte 4w+k
  endfunction

  function automatic logic [ctrlBits-1:0] expectedControls();
    mmioByteT phy0, phy1, phy2, diag1, diag2;
    phy0  = shadowRegs[7'h11];
    phy1  = shadowRegs[7'h12];
    phy2  = shadowRegs[7'h13];
    diag1 = shadowRegs[7'h74];
    diag2 = shadowRegs[7'h76];
    return {phy0[0], phy0[7:4], phy1[4:0], phy2[4:0], diag1[0], diag1[1], diag1[2],
            shadowRegs[7'h27], shadowRegs[7'h26], shadowRegs[7'h25],
            shadowRegs[7'h24], shadowRegs[7'h23], shadowRegs[7'h22],
            shadowRegs[7'h37], shadowRegs[7'h36], shadowRegs[7'h35], shadowRegs[7'h34],
            shadowRegs[7'h3B], shadowRegs[7'h3A], shadowRegs[7'h39], shadowRegs[7'h38],
            shadowRegs[7'h3F], shadowRegs[7'h3E], shadowRegs[7'h3D], shadowRegs[7'h3C],
            diag2[1:0], diag2[2], diag2[3], diag2[5:4], diag2[6], diag2[7]};
  endfunction

  // ---------------------------------------------------------------------------
  // Bus and fabric drivers
  // ---------------------------------------------------------------------------
  task automatic reportFailure(string msg);
    failCount++;
    $display("[ERROR] %0t ns %s", $time, msg);
    $display("Checks failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic nextSlot();
    @(posedge shlClk);
    #driveDelay;
  endtask

  task automatic idle();
    nextSlot();
    busCs    = 1'b0;
    busWe    = 1'b0;
    xmemEn   = 1'b0;
    xmemWren = 1'b0;
  endtask

  task automatic busWrite(mmioAddrT a, mmioByteT d);
    nextSlot();
    busCs     = 1'b1;
    busWe     = 1'b1;
    busAddr   = a;
    busWrData = d;
    xmemEn    = 1'b0;
    if (a[`MMIO_ADDR_WIDTH-1])
      shadowMem[{pageNow(), a[`REG_ADDR_WIDTH-1:0]}] = d;
    else if (isWritableRef(a[`REG_ADDR_WIDTH-1:0]))
      shadowRegs[a[`REG_ADDR_WIDTH-1:0]] = d;   // Read-only bytes keep their value
  endtask

  task automatic issueRead(mmioAddrT a);
    busCs   = 1'b1;
    busWe   = 1'b0;
    busAddr = a;
    xmemEn  = 1'b0;
    expQ.push_back(expectedRead(a));
    addrQ.push_back(a);
  endtask

  task automatic busRead(mmioAddrT a);
    nextSlot();
    issueRead(a);
  endtask

  // New status bits in the same slot as the read strobe
  task automatic statusRead();
    logic [31:0] r;
    nextSlot();
    r = lcgNext();
    {eth0QpllLock, eth0CoreReady, mc1InitCalComplete, mc0InitCalComplete} = r[19:16];
    issueRead({1'b0, `REG_PHY_STAT});
  endtask

  task automatic fabricWrite(xmemAddrT w, xmemWordT d);
    nextSlot();
    busCs      = 1'b0;
    xmemEn     = 1'b1;
    xmemWren   = 1'b1;
    xmemAddr   = w;
    xmemWrData = d;
    for (int k = 0; k < `XMEM_LANES; k++)
    begin
      shadowMem[{w, 2'(k)}] = d[8*k +: 8];
    end
  endtask

  task automatic fabricRead(xmemAddrT w);
    xmemWordT expWord;
    nextSlot();
    busCs    = 1'b0;
    xmemEn   = 1'b1;
    xmemWren = 1'b0;
    xmemAddr = w;
    expWord  = expectedWord(w);
    @(posedge shlClk);   // Word registered here
    #driveDelay;
    xmemEn = 1'b0;
    @(negedge shlClk);
    assert (xmemRdData === expWord)
      else reportFailure($sformatf("fabric word %h: got %h, expected %h",
                                   w, xmemRdData, expWord));
  endtask

  task automatic checkControls();
    @(negedge shlClk);
    assert (ctrlActual === expectedControls())
      else reportFailure($sformatf("control outputs: got %h, expected %h",
                                   ctrlActual, expectedControls()));
  endtask

  task automatic drainReads();
    while (expQ.size() != 0)
    begin
      idle();
    end
  endtask

  // ---------------------------------------------------------------------------
  // Read return checker
  // ---------------------------------------------------------------------------
  always @(negedge shlClk)
  begin : compareReads
    mmioByteT expByte;
    mmioAddrT expAddr;
    if (!reset && busRdValid)
    begin
      assert (expQ.size() != 0)
        else reportFailure("busRdValid was high with no read outstanding");
      expByte = expQ.pop_front();
      expAddr = addrQ.pop_front();
      assert (busRdData === expByte)
        else reportFailure($sformatf("read %h: got %h, expected %h",
                                     expAddr, busRdData, expByte));
    end
  end

  initial
  begin : watchdog
    #(watchdogCycles * clkPeriod);
    $display("Watchdog expired after %0d cycles and the test had not finished",
             watchdogCycles);
    $display("Checks failed");
    $fatal(1, "Timeout");
  end

  // ---------------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------------
  initial
  begin : stimulus
    logic [31:0] r;
    regAddrT     offs [burstLen];
    pageSelT     page;
    ramByteAddrT byteAddr;
    xmemAddrT    w;
    failCount  = 0;
    lcgState   = 32'd28;
    reset      = 1'b1;
    busCs      = 1'b1;   // Read strobe held through reset must never come back
    busWe      = 1'b0;
    busAddr    = '0;
    busWrData  = '0;
    xmemEn     = 1'b0;
    xmemWren   = 1'b0;
    xmemAddr   = '0;
    xmemWrData = '0;
    {eth0QpllLock, eth0CoreReady, mc1InitCalComplete, mc0InitCalComplete} = 4'b0000;
    for (int i = 0; i < `REG_FILE_BYTES; i++)
    begin
      shadowRegs[i] = defaultByte(regAddrT'(i));
    end
    repeat (5) @(posedge shlClk);
    #driveDelay;
    reset = 1'b0;
    busCs = 1'b0;

    // Defaults on every register and control output
    checkControls();
    for (int i = 0; i < `REG_FILE_BYTES; i++)
    begin
      busRead(mmioAddrT'(i));   // Back to back
    end
    drainReads();

    // Random write to every offset with outputs checked the cycle after
    for (int i = 0; i < `REG_FILE_BYTES; i++)
    begin
      r = lcgNext();
      busWrite(mmioAddrT'(i), r[23:16]);
      idle();
      checkControls();
    end
    for (int i = 0; i < `REG_FILE_BYTES; i++)
    begin
      busRead(mmioAddrT'(i));
    end
    drainReads();

    repeat (statusReads) statusRead();
    drainReads();

    // Known contents in the whole memory
    for (int i = 0; i < `XMEM_BYTES/`XMEM_LANES; i++)
    begin
      fabricWrite(xmemAddrT'(i), lcgNext());
    end
    idle();

    repeat (memRounds)
    begin
      r = lcgNext();
      busWrite({1'b0, `REG_PAGE_SEL}, r[23:16]);   // Upper bits do not page
      page = r[19:16];
      for (int k = 0; k < burstLen; k++)
      begin
        r       = lcgNext();
        offs[k] = r[22:16];
        busWrite({1'b1, offs[k]}, r[31:24]);
      end
      for (int k = 0; k < burstLen; k++)
      begin
        byteAddr = {page, offs[k]};
        fabricRead(byteAddr[`PAGE_BITS+`REG_ADDR_WIDTH-1:2]);
      end
      // Word write seen byte by byte through its page
      r = lcgNext();
      w = r[24:16];
      fabricWrite(w, lcgNext());
      busWrite({1'b0, `REG_PAGE_SEL}, {4'h0, w[8:5]});
      for (int k = 0; k < `XMEM_LANES; k++)
      begin
        busRead({1'b1, w[4:0], 2'(k)});
      end
      repeat (burstLen)
      begin
        r = lcgNext();
        busRead({1'b1, r[22:16]});
      end
      drainReads();
    end

    idle();
    if (failCount == 0)
    begin
      $display("All checks passed");
    end
    else
    begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/emifRegFile.sv ====
// Fixed 128-byte map; identification bytes are constants and unlisted offsets read zero
`timescale 1ns/1ps
`default_nettype none

`include "mmioClient_cfg.svh"

module emifRegFile
  import mmioPkg::*;
(
  input  logic        shlClk,
  input  logic        reset,
  mmioAccessIf.target regAcc,
  // Status inputs
  input  logic        mc0InitCalComplete,
  input  logic        mc1InitCalComplete,
  input  logic        eth0CoreReady,
  input  logic        eth0QpllLock,
  output pageSelT     pageSel,
  // Transceiver and MAC controls
  output logic        eth0RxEqualizerMode,
  output logic [3:0]  eth0TxDriverSwing,
  output logic [4:0]  eth0TxPreCursor,
  output logic [4:0]  eth0TxPostCursor,
  output logic        eth0PcsLoopbackEn,
  output logic        eth0MacLoopbackEn,
  output logic        eth0MacAddrSwapEn,
  // Network stack addresses
  output logic [47:0] nts0MacAddress,
  output logic [31:0] nts0IpAddress,
  output logic [31:0] nts0SubNetMask,
  output logic [31:0] nts0GatewayAddr,
  // Role test controls
  output logic [1:0]  roleUdpEchoCtrl,
  output logic        roleUdpPostPktEn,
  output logic        roleUdpCaptPktEn,
  output logic [1:0]  roleTcpEchoCtrl,
  output logic        roleTcpPostPktEn,
  output logic        roleTcpCaptPktEn
);

  localparam logic [3*`MMIO_DATA_WIDTH-1:0] defPhyEth0 = `DEF_PHY_ETH0;
  localparam logic [4*`MMIO_DATA_WIDTH-1:0] defLy3Snm = `DEF_LY3_SNM;
  localparam logic [4*`MMIO_DATA_WIDTH-1:0] defLy3Gtw = `DEF_LY3_GTW;
  localparam logic [4*`MMIO_DATA_WIDTH-1:0] defScratch = `DEF_DIAG_SCRATCH;

  mmioByteT regs [0:`REG_FILE_BYTES-1];  // Only writable entries ever change
  mmioByteT statusByte;
  mmioByteT readByte;

  // -------------------------------------------------------------------------
  // Map helpers
  // -------------------------------------------------------------------------
  // Offsets that accept bus writes
  function automatic logic isWritable(regAddrT a);
    return a inside {[`REG_PHY_ETH0 : `REG_PHY_ETH0+2], `REG_LY2_CTRL,
                     [`REG_LY2_MAC0 : `REG_LY2_MAC0+5],
                     [`REG_LY3_CTRL0 : `REG_LY3_CTRL0+1],
                     [`REG_LY3_IP0 : `REG_LY3_GTW0+3],
                     [`REG_DIAG_SCRATCH0 : `REG_DIAG_SCRATCH0+3],
                     `REG_DIAG_CTRL1, `REG_DIAG_CTRL2, `REG_PAGE_SEL};
  endfunction

  // Reset value per offset
  function automatic mmioByteT defaultOf(regAddrT a);
    mmioByteT d;
    case (a) inside
      `REG_EMIF_ID:   d = `DEF_EMIF_ID;
      `REG_EMIF_VER:  d = `DEF_EMIF_VER;
      `REG_EMIF_REV:  d = `DEF_EMIF_REV;
      `REG_EMIF_RSVD: d = `DEF_EMIF_RSVD;
      `REG_TOP_ID:    d = `DEF_TOP_ID;
      `REG_TOP_YEAR:  d = `TOP_DATE_YEAR;
      `REG_TOP_MONTH: d = `TOP_DATE_MONTH;
      `REG_TOP_DAY:   d = `TOP_DATE_DAY;
      [`REG_PHY_ETH0 : `REG_PHY_ETH0+2]:
        d = defPhyEth0[8*(a-`REG_PHY_ETH0) +: 8];
      [`REG_LY3_SNM0 : `REG_LY3_SNM0+3]:
        d = defLy3Snm[8*(a-`REG_LY3_SNM0) +: 8];
      [`REG_LY3_GTW0 : `REG_LY3_GTW0+3]:
        d = defLy3Gtw[8*(a-`REG_LY3_GTW0) +: 8];
      [`REG_DIAG_SCRATCH0 : `REG_DIAG_SCRATCH0+3]:
        d = defScratch[8*(a-`REG_DIAG_SCRATCH0) +: 8];
      default:        d = '0;   // Everything else clears
    endcase
    return d;
  endfunction

  // -------------------------------------------------------------------------
  // Storage
  // -------------------------------------------------------------------------
  always_ff @(posedge shlClk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `REG_FILE_BYTES; i++)
      begin
        regs[i] <= defaultOf(regAddrT'(i));
      end
    end
    else if (regAcc.sel && regAcc.we && isWritable(regAcc.offset))
    begin
      regs[regAcc.offset] <= regAcc.wrData;   // Read-only and holes drop the write
    end
  end

  // -------------------------------------------------------------------------
  // Read path
  // -------------------------------------------------------------------------
  assign statusByte = {4'b0000, eth0QpllLock, eth0CoreReady,
                       mc1InitCalComplete, mc0InitCalComplete};

  always_comb
  begin
    if (regAcc.offset inside {[`REG_EMIF_ID : `REG_TOP_DAY]})
      readByte = defaultOf(regAcc.offset);  // Burned-in identity
    else if (regAcc.offset == `REG_PHY_STAT)
      readByte = statusByte;                // Sampled at the strobe
    else if (isWritable(regAcc.offset))
      readByte = regs[regAcc.offset];
    else
      readByte = '0;
  end

  always_ff @(posedge shlClk)
  begin
    if (regAcc.sel && !regAcc.we)
    begin
      regAcc.rdData <= readByte;
    end
  end

  // -------------------------------------------------------------------------
  // Control fields
  // -------------------------------------------------------------------------
  assign eth0RxEqualizerMode = regs[`REG_PHY_ETH0][0];
  assign eth0TxDriverSwing   = regs[`REG_PHY_ETH0][7:4];
  assign eth0TxPreCursor     = regs[`REG_PHY_ETH0+1][4:0];
  assign eth0TxPostCursor    = regs[`REG_PHY_ETH0+2][4:0];

  // Lowest address lands in the LSB
  assign nts0MacAddress  = {regs[`REG_LY2_MAC0+5], regs[`REG_LY2_MAC0+4],
                            regs[`REG_LY2_MAC0+3], regs[`REG_LY2_MAC0+2],
                            regs[`REG_LY2_MAC0+1], regs[`REG_LY2_MAC0]};
  assign nts0IpAddress   = {regs[`REG_LY3_IP0+3], regs[`REG_LY3_IP0+2],
                            regs[`REG_LY3_IP0+1], regs[`REG_LY3_IP0]};
  assign nts0SubNetMask  = {regs[`REG_LY3_SNM0+3], regs[`REG_LY3_SNM0+2],
                            regs[`REG_LY3_SNM0+1], regs[`REG_LY3_SNM0]};
  assign nts0GatewayAddr = {regs[`REG_LY3_GTW0+3], regs[`REG_LY3_GTW0+2],
                            regs[`REG_LY3_GTW0+1], regs[`REG_LY3_GTW0]};

  assign eth0PcsLoopbackEn = regs[`REG_DIAG_CTRL1][0];
  assign eth0MacLoopbackEn = regs[`REG_DIAG_CTRL1][1];
  assign eth0MacAddrSwapEn = regs[`REG_DIAG_CTRL1][2];

  assign roleUdpEchoCtrl  = regs[`REG_DIAG_CTRL2][1:0];  // UDP in low nibble
  assign roleUdpPostPktEn = regs[`REG_DIAG_CTRL2][2];
  assign roleUdpCaptPktEn = regs[`REG_DIAG_CTRL2][3];
  assign roleTcpEchoCtrl  = regs[`REG_DIAG_CTRL2][5:4];  // TCP in high nibble
  assign roleTcpPostPktEn = regs[`REG_DIAG_CTRL2][6];
  assign roleTcpCaptPktEn = regs[`REG_DIAG_CTRL2][7];

  // Full byte reads back, only the low bits page the window
  assign pageSel = regs[`REG_PAGE_SEL][`PAGE_BITS-1:0];

endmodule

`default_nettype wire

// ==== verilog/mmioAccessIf.sv ====
// One decoded single-cycle access; no handshake, the target answers a read one cycle later
`timescale 1ns/1ps
`default_nettype none

interface mmioAccessIf
  import mmioPkg::*;
();

  logic     sel;     // Strobe, one cycle per access
  logic     we;      // Write when set, else read
  regAddrT  offset;  // Register index or in-page offset
  mmioByteT wrData;
  mmioByteT rdData;  // Registered by the target

  // Bus decoder side
  modport initiator (
    output sel,
    output we,
    output offset,
    output wrData,
    input  rdData
  );

  // Register file or memory side
  modport target (
    input  sel,
    input  we,
    input  offset,
    input  wrData,
    output rdData
  );

endinterface

`default_nettype wire

// ==== verilog/mmioBusDecode.sv ====
// Bus strobes must be single-cycle and synchronous to shlClk; reads return after one cycle
`timescale 1ns/1ps
`default_nettype none

`include "mmioClient_cfg.svh"

module mmioBusDecode
  import mmioPkg::*;
(
  input  logic     shlClk,
  input  logic     reset,
  input  logic     busCs,       // Access strobe
  input  logic     busWe,       // Write qualifier
  input  mmioAddrT busAddr,
  input  mmioByteT busWrData,
  output mmioByteT busRdData,
  output logic     busRdValid,
  mmioAccessIf.initiator regAcc,
  mmioAccessIf.initiator ramAcc
);

  logic ramHit;      // Upper half of the bus space
  logic busRead;
  logic rdFromRam;   // Target of the read in flight

  // -------------------------------------------------------------------------
  // Address split
  // -------------------------------------------------------------------------
  assign ramHit  = busAddr[`MMIO_ADDR_WIDTH-1];
  assign busRead = busCs & ~busWe;

  // Register file gets the lower 128 bytes
  assign regAcc.sel    = busCs & ~ramHit;
  assign regAcc.we     = busWe;
  assign regAcc.offset = busAddr[`REG_ADDR_WIDTH-1:0];
  assign regAcc.wrData = busWrData;

  // Page window gets the upper 128 bytes
  assign ramAcc.sel    = busCs & ramHit;
  assign ramAcc.we     = busWe;
  assign ramAcc.offset = busAddr[`REG_ADDR_WIDTH-1:0];
  assign ramAcc.wrData = busWrData;

  // -------------------------------------------------------------------------
  // Read return
  // -------------------------------------------------------------------------
  always_ff @(posedge shlClk)
  begin
    if (reset)
    begin
      busRdValid <= 1'b0;
      rdFromRam  <= 1'b0;
    end
    else
    begin
      busRdValid <= busRead;     // Exactly one cycle after the strobe
      if (busRead)
      begin
        rdFromRam <= ramHit;     // Remember who answers
      end
    end
  end

  // Both targets register their data on the same edge as rdFromRam
  assign busRdData = rdFromRam ? ramAcc.rdData : regAcc.rdData;

endmodule

`default_nettype wire

// ==== verilog/mmioClient.sv ====
// Bus strobes are single-cycle with no back-pressure and must be synchronous to shlClk
`timescale 1ns/1ps
`default_nettype none

module mmioClient
  import mmioPkg::*;
(
  input  logic        shlClk,
  input  logic        reset,
  // Bus from the management controller
  input  logic        busCs,
  input  logic        busWe,
  input  mmioAddrT    busAddr,
  input  mmioByteT    busWrData,
  output mmioByteT    busRdData,
  output logic        busRdValid,
  // Status inputs
  input  logic        mc0InitCalComplete,
  input  logic        mc1InitCalComplete,
  input  logic        eth0CoreReady,
  input  logic        eth0QpllLock,
  // Ethernet controls
  output logic        eth0RxEqualizerMode,
  output logic [3:0]  eth0TxDriverSwing,
  output logic [4:0]  eth0TxPreCursor,
  output logic [4:0]  eth0TxPostCursor,
  output logic        eth0PcsLoopbackEn,
  output logic        eth0MacLoopbackEn,
  output logic        eth0MacAddrSwapEn,
  // Network addresses
  output logic [47:0] nts0MacAddress,
  output logic [31:0] nts0IpAddress,
  output logic [31:0] nts0SubNetMask,
  output logic [31:0] nts0GatewayAddr,
  // Role controls
  output logic [1:0]  roleUdpEchoCtrl,
  output logic        roleUdpPostPktEn,
  output logic        roleUdpCaptPktEn,
  output logic [1:0]  roleTcpEchoCtrl,
  output logic        roleTcpPostPktEn,
  output logic        roleTcpCaptPktEn,
  // Fabric word port
  input  logic        xmemEn,
  input  logic        xmemWren,
  input  xmemAddrT    xmemAddr,
  input  xmemWordT    xmemWrData,
  output xmemWordT    xmemRdData
);

  pageSelT pageSel;     // Register file to memory

  mmioAccessIf regAcc ();
  mmioAccessIf ramAcc ();

  // -------------------------------------------------------------------------
  // Instances
  // -------------------------------------------------------------------------
  mmioBusDecode busDecode (
    .shlClk, .reset, .busCs, .busWe, .busAddr, .busWrData, .busRdData, .busRdValid,
    .regAcc (regAcc.initiator),
    .ramAcc (ramAcc.initiator)
  );

  emifRegFile regFile (
    .shlClk, .reset,
    .regAcc (regAcc.target),
    .mc0InitCalComplete, .mc1InitCalComplete, .eth0CoreReady, .eth0QpllLock,
    .pageSel,
    .eth0RxEqualizerMode, .eth0TxDriverSwing, .eth0TxPreCursor, .eth0TxPostCursor,
    .eth0PcsLoopbackEn, .eth0MacLoopbackEn, .eth0MacAddrSwapEn,
    .nts0MacAddress, .nts0IpAddress, .nts0SubNetMask, .nts0GatewayAddr,
    .roleUdpEchoCtrl, .roleUdpPostPktEn, .roleUdpCaptPktEn,
    .roleTcpEchoCtrl, .roleTcpPostPktEn, .roleTcpCaptPktEn
  );

  xmemDualPortRam xmem (
    .shlClk,
    .ramAcc (ramAcc.target),
    .pageSel,
    .xmemEn, .xmemWren, .xmemAddr, .xmemWrData, .xmemRdData
  );

endmodule

`default_nettype wire

// ==== verilog/mmioClient_cfg.svh ====
// Fixed register map and build identity; the bus must be synchronous to the shell clock
`ifndef MMIO_CLIENT_CFG_SVH
`define MMIO_CLIENT_CFG_SVH

// ---------------------------------------------------------------------------
// Widths and sizes
// ---------------------------------------------------------------------------
`define MMIO_ADDR_WIDTH     8       // Bus address, bit 7 picks the target
`define MMIO_DATA_WIDTH     8
`define REG_ADDR_WIDTH      7       // Register index or in-page offset
`define PAGE_BITS           4       // 16 pages of 128 bytes
`define XMEM_ADDR_WIDTH     9
`define XMEM_DATA_WIDTH     32
`define REG_FILE_BYTES      128
`define XMEM_BYTES          2048
`define XMEM_LANES          4       // Bytes per fabric word

// ---------------------------------------------------------------------------
// Register addresses
// ---------------------------------------------------------------------------
`define REG_EMIF_ID         7'h00   // Identification block, read only
`define REG_EMIF_VER        7'h01
`define REG_EMIF_REV        7'h02
`define REG_EMIF_RSVD       7'h03
`define REG_TOP_ID          7'h04
`define REG_TOP_YEAR        7'h05
`define REG_TOP_MONTH       7'h06
`define REG_TOP_DAY         7'h07
`define REG_PHY_STAT        7'h10   // Live status inputs
`define REG_PHY_ETH0        7'h11   // Three bytes of transceiver tuning
`define REG_LY2_CTRL        7'h20
`define REG_LY2_MAC0        7'h22   // Six bytes, LSB first
`define REG_LY3_CTRL0       7'h30   // Two bytes
`define REG_LY3_IP0         7'h34
`define REG_LY3_SNM0        7'h38
`define REG_LY3_GTW0        7'h3C
`define REG_DIAG_SCRATCH0   7'h70   // Four bytes
`define REG_DIAG_CTRL1      7'h74
`define REG_DIAG_CTRL2      7'h76
`define REG_PAGE_SEL        7'h7F

// ---------------------------------------------------------------------------
// Reset defaults, multi-byte values have the lowest address in the LSB
// ---------------------------------------------------------------------------
`define DEF_EMIF_ID         8'h3D
`define DEF_EMIF_VER        8'h01
`define DEF_EMIF_REV        8'h00
`define DEF_EMIF_RSVD       8'h33
`define DEF_TOP_ID          8'h01
`define TOP_DATE_YEAR       8'h18
`define TOP_DATE_MONTH      8'h0B
`define TOP_DATE_DAY        8'h15
`define DEF_PHY_ETH0        24'h050541
`define DEF_LY3_SNM         32'h0000FFFF   // 255.255.0.0
`define DEF_LY3_GTW         32'h0100020A   // 10.2.0.1
`define DEF_DIAG_SCRATCH    32'hEFBEADDE

`endif

// ==== verilog/mmioPkg.sv ====
// Vector types only; widths follow the fixed map in the config header
`default_nettype none

`include "mmioClient_cfg.svh"

package mmioPkg;

  // -------------------------------------------------------------------------
  // Bus side
  // -------------------------------------------------------------------------
  typedef logic [`MMIO_ADDR_WIDTH-1:0] mmioAddrT;  // Full bus address
  typedef logic [`MMIO_DATA_WIDTH-1:0] mmioByteT;  // Bus data byte

  // Register index, also the offset inside a memory page
  typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;

  typedef logic [`PAGE_BITS-1:0] pageSelT;         // Used page-select bits

  // Byte address into the page memory, page above offset
  typedef logic [`PAGE_BITS+`REG_ADDR_WIDTH-1:0] ramByteAddrT;

  // -------------------------------------------------------------------------
  // Fabric side
  // -------------------------------------------------------------------------
  typedef logic [`XMEM_ADDR_WIDTH-1:0] xmemAddrT;  // Word address
  typedef logic [`XMEM_DATA_WIDTH-1:0] xmemWordT;  // Four lanes

endpackage

`default_nettype wire

// ==== verilog/xmemDualPortRam.sv ====
// Single clock only; same-cycle writes to one byte from both ports leave it undefined
`timescale 1ns/1ps
`default_nettype none

`include "mmioClient_cfg.svh"

module xmemDualPortRam
  import mmioPkg::*;
(
  input  logic     shlClk,
  mmioAccessIf.target ramAcc,      // Byte port from the bus window
  input  pageSelT  pageSel,
  input  logic     xmemEn,         // Word port from the fabric
  input  logic     xmemWren,
  input  xmemAddrT xmemAddr,
  input  xmemWordT xmemWrData,
  output xmemWordT xmemRdData
);

  localparam int laneBits = $clog2(`XMEM_LANES);

  // Lane k of a word holds byte 4w+k
  mmioByteT [`XMEM_LANES-1:0] mem [0:`XMEM_BYTES/`XMEM_LANES-1];

  ramByteAddrT         byteAddr;
  xmemAddrT            byteWord;   // Word holding the bus byte
  logic [laneBits-1:0] byteLane;

  // -------------------------------------------------------------------------
  // Byte address split
  // -------------------------------------------------------------------------
  assign byteAddr             = {pageSel, ramAcc.offset};
  assign {byteWord, byteLane} = byteAddr;

  // -------------------------------------------------------------------------
  // Both ports, one clock
  // -------------------------------------------------------------------------
  always_ff @(posedge shlClk)
  begin
    // Byte port
    if (ramAcc.sel)
    begin
      if (ramAcc.we)
        mem[byteWord][byteLane] <= ramAcc.wrData;
      else
        ramAcc.rdData <= mem[byteWord][byteLane];  // Registered read
    end
    // Word port, all four lanes
    if (xmemEn)
    begin
      if (xmemWren)
        mem[xmemAddr] <= xmemWrData;
      else
        xmemRdData <= mem[xmemAddr];
    end
  end

endmodule

`default_nettype wire
